//--- logic/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Data and address width
`define RV_XLEN 32
// Architectural register count and index width
`define RV_REG_COUNT 32
`define RV_REG_ADDR_W 5

// PC after reset and sequential step
`define RV_RESET_PC 32'h0000_0000
`define RV_INSTR_BYTES 4

// Major opcodes, instruction bits [6:0]
`define RV_OP_LUI 7'b0110111
`define RV_OP_AUIPC 7'b0010111
`define RV_OP_JAL 7'b1101111
`define RV_OP_JALR 7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD 7'b0000011
`define RV_OP_STORE 7'b0100011
`define RV_OP_IMM 7'b0010011
`define RV_OP_REG 7'b0110011

`endif

//--- logic/rv_pkg.sv
`include "rv_macros.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;
    // One enable bit per byte lane
    typedef logic [`RV_XLEN/8-1:0] strobe_t;

    // Encoded as {instr[30], funct3}
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_t;

    // Next PC source
    typedef enum logic [1:0] {pc_seq, pc_rel, pc_reg} pc_sel_t;
    // First ALU operand source
    typedef enum logic {op_a_reg, op_a_pc} op_a_sel_t;
    // Register write-back source
    typedef enum logic [1:0] {wb_alu, wb_mem, wb_link} wb_sel_t;

endpackage

//--- logic/rv_alu.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_alu import rv_pkg::*; (
    input  alu_op_t    op,
    input  word_t      a,
    input  word_t      b,
    input  logic [2:0] funct3,
    output word_t      result,
    output logic       cond_true
);

    // Shift amount is the low five bits of b
    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];

    // Shared comparators for SLT/SLTU and branches
    assign eq   = (a == b);
    assign lt_s = ($signed(a) < $signed(b));
    assign lt_u = (a < b);

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {{(`RV_XLEN-1){1'b0}}, lt_s};
            alu_sltu: result = {{(`RV_XLEN-1){1'b0}}, lt_u};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            // Arithmetic shift keeps the sign
            alu_sra:  result = word_t'($signed(a) >>> shamt);
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = '0;
        endcase
    end

    // Branch condition by funct3
    always_comb begin
        case (funct3)
            3'b000:  cond_true = eq;
            3'b001:  cond_true = !eq;
            3'b100:  cond_true = lt_s;
            3'b101:  cond_true = !lt_s;
            3'b110:  cond_true = lt_u;
            3'b111:  cond_true = !lt_u;
            // Reserved encodings never branch
            default: cond_true = 1'b0;
        endcase
    end

endmodule

//--- logic/rv_reg_file.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_reg_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  reg_addr_t rd_addr,
    input  logic      rd_we,
    input  word_t     rd_data,
    output word_t     rs1_data,
    output word_t     rs2_data
);

    // x1 to x31, x0 has no storage
    word_t regs [1:`RV_REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && (rd_addr != '0)) begin
            // Writes to x0 are dropped
            regs[rd_addr] <= rd_data;
        end
    end

    // Combinational reads, x0 reads zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- logic/rv_decoder.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_decoder import rv_pkg::*; (
    input  word_t     idata,
    input  logic      cond_true,
    output alu_op_t   alu_op,
    output op_a_sel_t op_a_sel,
    output logic      use_imm,
    output word_t     imm,
    output word_t     pc_off,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output reg_addr_t rd_addr,
    output logic      rd_we,
    output wb_sel_t   wb_sel,
    output pc_sel_t   pc_sel,
    output strobe_t   dwe
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_shift;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_u;
    word_t      off_b;
    word_t      off_j;

    assign opcode = idata[6:0];
    assign funct3 = idata[14:12];

    // SLLI, SRLI and SRAI take instr[30] into the ALU op
    assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

    // Immediates for the second ALU operand
    assign imm_i = {{20{idata[31]}}, idata[31:20]};
    assign imm_s = {{20{idata[31]}}, idata[31:25], idata[11:7]};
    assign imm_u = {idata[31:12], 12'b0};

    // PC-relative offsets, always even
    assign off_b = {{19{idata[31]}}, idata[31], idata[7], idata[30:25], idata[11:8], 1'b0};
    assign off_j = {{11{idata[31]}}, idata[31], idata[19:12], idata[20], idata[30:21], 1'b0};

    // Only JAL uses the J offset, branches use B
    assign pc_off = (opcode == `RV_OP_JAL) ? off_j : off_b;

    always_comb begin
        // Register fields come straight from the instruction
        rs1_addr = idata[19:15];
        rs2_addr = idata[24:20];
        rd_addr  = idata[11:7];
        alu_op   = alu_add;
        op_a_sel = op_a_reg;
        use_imm  = 1'b0;
        imm      = imm_i;
        // Safe defaults, no architectural side effects
        rd_we    = 1'b0;
        wb_sel   = wb_alu;
        pc_sel   = pc_seq;
        dwe      = '0;

        case (opcode)
            `RV_OP_LUI: begin
                // x0 + upper immediate
                rs1_addr = '0;
                use_imm  = 1'b1;
                imm      = imm_u;
                rd_we    = 1'b1;
            end
            `RV_OP_AUIPC: begin
                op_a_sel = op_a_pc;
                use_imm  = 1'b1;
                imm      = imm_u;
                rd_we    = 1'b1;
            end
            `RV_OP_JAL: begin
                rd_we  = 1'b1;
                wb_sel = wb_link;
                pc_sel = pc_rel;
            end
            `RV_OP_JALR: begin
                // Target is rs1 + imm, computed by the ALU
                use_imm = 1'b1;
                alu_op  = alu_add;
                rd_we   = 1'b1;
                wb_sel  = wb_link;
                pc_sel  = pc_reg;
            end
            `RV_OP_BRANCH: begin
                // ALU compares rs1 with rs2
                pc_sel = cond_true ? pc_rel : pc_seq;
            end
            `RV_OP_LOAD: begin
                use_imm = 1'b1;
                wb_sel  = wb_mem;
                // Word loads only
                rd_we   = (funct3 == 3'b010);
            end
            `RV_OP_STORE: begin
                use_imm = 1'b1;
                imm     = imm_s;
                // Full-word strobe for SW, nothing else stores
                if (funct3 == 3'b010) begin
                    dwe = '1;
                end
            end
            `RV_OP_IMM: begin
                use_imm = 1'b1;
                rd_we   = 1'b1;
                if (is_shift) begin
                    alu_op = alu_op_t'({idata[30], funct3});
                end else begin
                    // instr[30] is immediate data here
                    alu_op = alu_op_t'({1'b0, funct3});
                end
            end
            `RV_OP_REG: begin
                rd_we  = 1'b1;
                alu_op = alu_op_t'({idata[30], funct3});
            end
            default: begin
                // Unknown opcode acts as a no-op
                rd_we = 1'b0;
            end
        endcase
    end

endmodule

//--- logic/rv_core.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_core import rv_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  word_t   idata,
    input  word_t   drdata,
    output word_t   iaddr,
    output word_t   daddr,
    output word_t   dwdata,
    output strobe_t dwe
);

    alu_op_t   alu_op;
    op_a_sel_t op_a_sel;
    logic      use_imm;
    word_t     imm;
    word_t     pc_off;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    logic      rd_we;
    wb_sel_t   wb_sel;
    pc_sel_t   pc_sel;
    logic      cond_true;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     rd_data;
    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_result;
    word_t     pc_plus4;
    word_t     next_pc;

    // Control unit
    rv_decoder u_rv_decoder (
        .idata    (idata),
        .cond_true(cond_true),
        .alu_op   (alu_op),
        .op_a_sel (op_a_sel),
        .use_imm  (use_imm),
        .imm      (imm),
        .pc_off   (pc_off),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_addr  (rd_addr),
        .rd_we    (rd_we),
        .wb_sel   (wb_sel),
        .pc_sel   (pc_sel),
        .dwe      (dwe)
    );

    rv_reg_file u_rv_reg_file (
        .clk     (clk),
        .reset   (reset),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rd_addr (rd_addr),
        .rd_we   (rd_we),
        .rd_data (rd_data),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data)
    );

    // Operand muxes
    assign alu_a = (op_a_sel == op_a_pc) ? iaddr : rs1_data;
    assign alu_b = use_imm ? imm : rs2_data;

    rv_alu u_rv_alu (
        .op       (alu_op),
        .a        (alu_a),
        .b        (alu_b),
        .funct3   (idata[14:12]),
        .result   (alu_result),
        .cond_true(cond_true)
    );

    // Link value and sequential PC share one adder
    assign pc_plus4 = iaddr + word_t'(`RV_INSTR_BYTES);

    always_comb begin
        case (wb_sel)
            wb_mem:  rd_data = drdata;
            wb_link: rd_data = pc_plus4;
            default: rd_data = alu_result;
        endcase
    end

    always_comb begin
        case (pc_sel)
            pc_rel:  next_pc = iaddr + pc_off;
            // JALR target with bit 0 cleared
            pc_reg:  next_pc = {alu_result[`RV_XLEN-1:1], 1'b0};
            default: next_pc = pc_plus4;
        endcase
    end

    // PC register
    always_ff @(posedge clk) begin
        if (reset) begin
            iaddr <= `RV_RESET_PC;
        end else begin
            iaddr <= next_pc;
        end
    end

    // Data memory address and write data
    assign daddr  = alu_result;
    assign dwdata = rs2_data;

endmodule

//--- sim/rv_core_chk.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_core_chk import rv_pkg::*; (
    input logic    clk,
    input logic    reset,
    input word_t   iaddr,
    input strobe_t dwe
);

    // Only full-word stores exist
    a_dwe_full_or_none: assert property (@(posedge clk) (dwe == '0) || (dwe == '1))
        else $error("dwe is neither all zero nor all ones");

    // Every PC source keeps bit 0 clear
    a_iaddr_even: assert property (@(posedge clk) disable iff (reset) !iaddr[0])
        else $error("iaddr bit 0 set");

    // PC back at its start value once reset has been seen
    a_reset_pc: assert property (@(posedge clk) reset |=> (iaddr == `RV_RESET_PC))
        else $error("iaddr not at reset PC after reset");

endmodule

bind rv_core rv_core_chk u_rv_core_chk (
    .clk  (clk),
    .reset(reset),
    .iaddr(iaddr),
    .dwe  (dwe)
);

//--- sim/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_core_tb import rv_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    // Instructions issued by all tests plus the reset cycles
    localparam int TEST_INSTRS = 90;

    logic    clk;
    logic    reset;
    word_t   idata;
    word_t   drdata;
    word_t   iaddr;
    word_t   daddr;
    word_t   dwdata;
    strobe_t dwe;

    // Expected PC of the instruction on idata
    word_t pc = `RV_RESET_PC;
    // Base value held in x11 for loads and stores
    word_t base_val = '0;
    word_t lcg_state = 32'h2a876075;
    int    pass_count = 0;
    int    fail_count = 0;
    int    test_fail_base = 0;

    rv_core u_rv_core (
        .clk   (clk),
        .reset (reset),
        .idata (idata),
        .drdata(drdata),
        .iaddr (iaddr),
        .daddr (daddr),
        .dwdata(dwdata),
        .dwe   (dwe)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Numerical Recipes LCG constants
    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // Instruction encoders
    function automatic word_t enc_r(input logic alt, input reg_addr_t rs2, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, `RV_OP_REG};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic word_t enc_b(input logic [12:0] off, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
    endfunction

    function automatic word_t enc_u(input logic [19:0] u, input reg_addr_t rd,
                                    input logic [6:0] op);
        return {u, rd, op};
    endfunction

    function automatic word_t enc_j(input logic [20:0] off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
    endfunction

    // Expected ALU result from the RV32I definitions
    function automatic word_t alu_model(input logic alt, input logic [2:0] f3,
                                        input word_t a, input word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_strobe(input string name, input strobe_t got, input strobe_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    // Close the cycle at the next edge and resume stimulus 1 ns later
    task automatic finish_cycle(input word_t next_pc);
        @(posedge clk);
        #1;
        pc = next_pc;
    endtask

    // Non-memory instruction with a known successor PC
    task automatic exec(input word_t instr, input word_t next_pc);
        idata = instr;
        #5;
        check_word("iaddr", iaddr, pc);
        check_strobe("dwe", dwe, '0);
        finish_cycle(next_pc);
    endtask

    // Load a register through LUI and a sign-extended ADDI
    task automatic set_reg(input reg_addr_t rd, input word_t value);
        word_t upper;
        upper = (value + 32'h800) >> 12;
        exec(enc_u(upper[19:0], rd, `RV_OP_LUI), pc + 4);
        exec(enc_i(value[11:0], rd, 3'b000, rd, `RV_OP_IMM), pc + 4);
    endtask

    // SW rs2 to a random offset from x11
    task automatic store_check(input reg_addr_t rs2, input word_t exp_data);
        word_t rnd;
        rnd = lcg_next();
        idata = enc_s(rnd[11:0], rs2, 5'd11);
        #5;
        check_word("iaddr", iaddr, pc);
        check_strobe("dwe", dwe, 4'b1111);
        check_word("daddr", daddr, base_val + sext12(rnd[11:0]));
        check_word("dwdata", dwdata, exp_data);
        finish_cycle(pc + 4);
    endtask

    // LW rd from a random offset from x11 with memory returning data
    task automatic load_check(input reg_addr_t rd, input word_t data);
        word_t rnd;
        rnd = lcg_next();
        drdata = data;
        idata = enc_i(rnd[11:0], 5'd11, 3'b010, rd, `RV_OP_LOAD);
        #5;
        check_word("iaddr", iaddr, pc);
        check_strobe("dwe", dwe, '0);
        check_word("daddr", daddr, base_val + sext12(rnd[11:0]));
        finish_cycle(pc + 4);
    endtask

    task automatic branch_run(input logic [2:0] f3, input reg_addr_t rs1, input reg_addr_t rs2,
                              input word_t a, input word_t b);
        word_t rnd;
        word_t target;
        rnd = lcg_next();
        target = pc + {{19{rnd[12]}}, rnd[12:1], 1'b0};
        exec(enc_b({rnd[12:1], 1'b0}, rs2, rs1, f3), branch_model(f3, a, b) ? target : pc + 4);
    endtask

    task automatic report_test(input string name);
        $display("Test %s finished with %0d errors", name, fail_count - test_fail_base);
        test_fail_base = fail_count;
    endtask

    task automatic test_reset_flow();
        for (int i = 1; i <= 4; i++) begin
            exec(enc_i(12'(i), 5'd0, 3'b000, reg_addr_t'(i), `RV_OP_IMM), pc + 4);
        end
        // Untouched register still cleared by reset
        store_check(5'd15, '0);
        report_test("reset_flow");
    endtask

    task automatic test_alu_ops();
        word_t       a;
        word_t       b;
        word_t       rnd;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        base_val = lcg_next();
        set_reg(5'd11, base_val);
        a = lcg_next();
        b = lcg_next();
        set_reg(5'd1, a);
        set_reg(5'd2, b);
        // Eight funct3 codes then SUB and SRA
        for (int i = 0; i < 10; i++) begin
            f3 = (i < 8) ? 3'(i) : ((i == 8) ? 3'd0 : 3'd5);
            alt = (i >= 8);
            exec(enc_r(alt, 5'd2, 5'd1, f3, 5'd12), pc + 4);
            store_check(5'd12, alu_model(alt, f3, a, b));
        end
        // Eight immediate forms then SRAI
        for (int i = 0; i < 9; i++) begin
            f3 = (i < 8) ? 3'(i) : 3'd5;
            alt = (i == 8);
            rnd = lcg_next();
            imm = (f3 == 3'd1 || f3 == 3'd5) ? {1'b0, alt, 5'b0, rnd[4:0]} : rnd[11:0];
            exec(enc_i(imm, 5'd1, f3, 5'd12, `RV_OP_IMM), pc + 4);
            store_check(5'd12, alu_model(alt, f3, a, sext12(imm)));
        end
        exec(enc_r(1'b0, 5'd2, 5'd1, 3'd0, 5'd0), pc + 4);
        store_check(5'd0, '0);
        report_test("alu_ops");
    endtask

    task automatic test_upper_imm();
        word_t u;
        word_t auipc_pc;
        u = lcg_next();
        exec(enc_u(u[31:12], 5'd9, `RV_OP_LUI), pc + 4);
        store_check(5'd9, {u[31:12], 12'b0});
        u = lcg_next();
        auipc_pc = pc;
        exec(enc_u(u[31:12], 5'd10, `RV_OP_AUIPC), pc + 4);
        store_check(5'd10, auipc_pc + {u[31:12], 12'b0});
        report_test("upper_imm");
    endtask

    task automatic test_load_word();
        word_t data;
        data = lcg_next();
        load_check(5'd13, data);
        drdata = '0;
        store_check(5'd13, data);
        report_test("load_word");
    endtask

    task automatic test_branches();
        logic [2:0] conds [6];
        conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        set_reg(5'd3, 32'hffff_fffb);
        set_reg(5'd4, 32'd7);
        set_reg(5'd5, 32'd7);
        // Pairs cover taken and not taken for each condition
        foreach (conds[i]) begin
            branch_run(conds[i], 5'd3, 5'd4, 32'hffff_fffb, 32'd7);
            branch_run(conds[i], 5'd4, 5'd3, 32'd7, 32'hffff_fffb);
            branch_run(conds[i], 5'd4, 5'd5, 32'd7, 32'd7);
        end
        report_test("branches");
    endtask

    task automatic test_jumps();
        word_t       tgt;
        word_t       rnd;
        word_t       jal_pc;
        word_t       jalr_pc;
        logic [11:0] jalr_imm;
        // Odd base and even immediate give an odd JALR sum
        tgt = lcg_next() | 32'h1;
        set_reg(5'd8, tgt);
        rnd = lcg_next();
        jal_pc = pc;
        exec(enc_j({rnd[20:1], 1'b0}, 5'd6), pc + {{11{rnd[20]}}, rnd[20:1], 1'b0});
        rnd = lcg_next();
        jalr_pc = pc;
        jalr_imm = {rnd[11:1], 1'b0};
        // Target bit 0 dropped
        exec(enc_i(jalr_imm, 5'd8, 3'b000, 5'd7, `RV_OP_JALR),
             (tgt + sext12(jalr_imm)) & ~32'h1);
        store_check(5'd6, jal_pc + 4);
        store_check(5'd7, jalr_pc + 4);
        report_test("jumps");
    endtask

    // Watchdog sized from the test length plus margin
    initial begin
        #((TEST_INSTRS + 50) * CLK_PERIOD);
        $display("Timeout: the tests did not complete in the expected time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        reset = 1'b1;
        idata = enc_i(12'd0, 5'd0, 3'b000, 5'd0, `RV_OP_IMM);
        drdata = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_flow();
        test_alu_ops();
        test_upper_imm();
        test_load_word();
        test_branches();
        test_jumps();
        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+logic
logic/rv_pkg.sv
logic/rv_alu.sv
logic/rv_reg_file.sv
logic/rv_decoder.sv
logic/rv_core.sv
sim/rv_core_chk.sv
sim/rv_core_tb.sv
